// ==== verif/hazard_trace.txt ====
# name instr stall d_rs d_rt e_rs e_rt m_rt (instr in hex, the rest decimal)
# selects: 0 ODATA, 1 EDATA, 2 MDATA, 3 WDATA
reset_nop 00000000 0 0 0 0 0 0
reset_nop 00000000 0 0 0 0 0 0
load_use 8C280000 0 0 0 0 0 0
load_use 01024821 1 0 0 0 0 0
load_use 01024821 0 2 0 0 0 0
load_use 8C2A0004 0 0 0 3 0 0
load_use 00000000 0 0 0 0 0 0
load_use 00000000 0 0 0 0 0 0
load_use 01405821 0 3 0 0 0 0
alu_fwd 016B6021 0 1 1 0 0 0
alu_fwd 358D0005 0 1 0 2 2 0
alu_fwd 11AC0003 1 1 2 2 0 0
alu_fwd 11AC0003 0 2 3 0 0 0
alu_fwd 00000000 0 0 0 3 0 0
alu_fwd 00000000 0 0 0 0 0 0
lw_sw 8C2E0008 0 0 0 0 0 0
lw_sw AC2E000C 0 0 0 0 0 0
lw_sw 00000000 0 0 0 0 2 0
lw_sw 00000000 0 0 0 0 0 3
md_busy 00640018 0 0 0 0 0 0
md_busy 00007812 1 0 0 0 0 0
md_busy 00007812 1 0 0 0 0 0
md_busy 00007812 1 0 0 0 0 0
md_busy 00007812 1 0 0 0 0 0
md_busy 00007812 1 0 0 0 0 0
md_busy 00007812 1 0 0 0 0 0
md_busy 00007812 0 0 0 0 0 0
md_busy 00A60018 0 0 0 0 0 0
md_busy 01E08021 0 2 0 0 0 0
md_busy 36110001 0 1 0 3 0 0
md_busy 00000000 0 0 0 2 0 0
md_busy 00000000 0 0 0 0 0 0
md_busy 00000000 0 0 0 0 0 0
md_busy 00000000 0 0 0 0 0 0
reg_zero 8C200000 0 0 0 0 0 0
reg_zero 00009021 0 0 0 0 0 0
reg_zero 34000007 0 0 0 0 0 0
reg_zero 02409821 0 2 0 0 0 0
reg_zero 10000002 0 0 0 3 0 0
reg_zero 00000000 0 0 0 0 0 0
reg_zero 00000000 0 0 0 0 0 0
reg_zero 00000000 0 0 0 0 0 0

// ==== hazard_core.f ====
+incdir+common
common/hazard_pkg.sv
rtl/instr_decode.sv
rtl/stage_track.sv
rtl/md_busy.sv
rtl/hazard_ctrl.sv
rtl/hazard_core.sv
verif/hazard_checker.sv
verif/tb_hazard_core.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_hazard_core \
	-f hazard_core.f --Mdir build/obj_dir -o sim_hazard > build/compile.log 2>&1 \
	|| { cat build/compile.log; echo "Verilator compile failed"; exit 1; }
./build/obj_dir/sim_hazard > build/sim.log 2>&1
cat build/sim.log
grep -qx "TEST RESULT: PASS" build/sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== verif/tb_hazard_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hazard_macros.svh"

module tb_hazard_core import hazard_pkg::*; ();

	localparam int    RESET_CYCLES = 4;
	localparam int    PAD_CYCLES   = 8;
	localparam int    FIELDS       = 6;
	localparam string TRACE_FILE   = "verif/hazard_trace.txt";

	// One trace line: test name, D-stage word, expected outputs
	typedef struct packed {
		logic [127:0] name;
		logic [31:0]  instr;
		logic         stall;
		fwd_bundle_t  fwd;
	} trace_ent_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] instr;
	logic        stall;
	fwd_bundle_t fwd;
	logic        check_en;
	trace_ent_t  cur;
	int          err_cnt;
	int          chk_cnt;
	trace_ent_t  trace_q[$];
	logic        load_fail;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;

	hazard_core dut_i (
		.clk   (clk),
		.rst_n (rst_n),
		.instr (instr),
		.stall (stall),
		.fwd   (fwd)
	);

	hazard_checker chk_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.check_en  (check_en),
		.test_name (cur.name),
		.exp_stall (cur.stall),
		.exp_fwd   (cur.fwd),
		.stall     (stall),
		.fwd       (fwd),
		.err_cnt   (err_cnt),
		.chk_cnt   (chk_cnt)
	);

	always #5 clk = ~clk;

	task automatic load_trace();
		int           fd;
		int           n;
		int           st;
		int           sel [5];
		logic [127:0] name;
		logic [31:0]  word;
		string        line;
		trace_ent_t   ent;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the trace file %s", TRACE_FILE);
			load_fail = 1'b1;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %h %d %d %d %d %d %d", name, word, st,
				            sel[0], sel[1], sel[2], sel[3], sel[4]);
				if (n != 8 || st > 1 || sel[0] > 3 || sel[1] > 3 || sel[2] > 3 ||
				    sel[3] > 3 || sel[4] > 3) begin
					$display("Trace line could not be read: %s", line);
					load_fail = 1'b1;
				end else begin
					ent.name     = name;
					ent.instr    = word;
					ent.stall    = st[0];
					ent.fwd.d_rs = fwd_sel_e'(sel[0][1:0]);
					ent.fwd.d_rt = fwd_sel_e'(sel[1][1:0]);
					ent.fwd.e_rs = fwd_sel_e'(sel[2][1:0]);
					ent.fwd.e_rt = fwd_sel_e'(sel[3][1:0]);
					ent.fwd.m_rt = fwd_sel_e'(sel[4][1:0]);
					trace_q.push_back(ent);
				end
			end
		end
		$fclose(fd);
	endtask

	// Shift-by-zero words decode as no-ops; the trace leaves the pipeline empty
	task automatic append_padding();
		trace_ent_t ent;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		for (int i = 0; i < PAD_CYCLES; i++) begin
			rs = 5'($urandom % 32);
			rt = 5'($urandom % 32);
			rd = 5'($urandom % 32);
			ent = '0;
			ent.name = "pad_nop";
			ent.instr = {`OP_SPECIAL, rs, rt, rd, 5'd0, 6'd0};
			trace_q.push_back(ent);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus, one trace line per cycle on the falling edge

	initial begin
		int expected_checks;
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		check_en = 1'b0;
		cur = '0;
		load_fail = 1'b0;
		void'($urandom(38190));
		load_trace();
		if (!load_fail) begin
			append_padding();
		end
		cycle_limit = trace_q.size() + RESET_CYCLES + 50;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		if (!load_fail) begin
			foreach (trace_q[i]) begin
				instr = trace_q[i].instr;
				cur = trace_q[i];
				check_en = 1'b1;
				@(negedge clk);
			end
		end
		check_en = 1'b0;
		expected_checks = FIELDS * trace_q.size();
		if (chk_cnt != expected_checks) begin
			$display("Only %0d of %0d checks were run", chk_cnt, expected_checks);
		end
		$display("Checks: %0d  errors: %0d", chk_cnt, err_cnt);
		if (!load_fail && err_cnt == 0 && chk_cnt == expected_checks) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Run limit
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verif/hazard_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_checker import hazard_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         check_en,
	input  logic [127:0] test_name,
	input  logic         exp_stall,
	input  fwd_bundle_t  exp_fwd,
	input  logic         stall,
	input  fwd_bundle_t  fwd,
	output int           err_cnt,
	output int           chk_cnt
);

	// One field; an X from the DUT never matches
	task automatic compare_field(input string field, input logic [1:0] exp_v,
	                             input logic [1:0] act_v);
		chk_cnt = chk_cnt + 1;
		if (act_v !== exp_v) begin
			err_cnt = err_cnt + 1;
			$display("ERR %0s %0s: expected %0d actual %0d at %0t",
			         test_name, field, exp_v, act_v, $time);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sampling

	// Outputs are combinational, so the value seen at the edge is the settled one
	always @(posedge clk) begin
		if (!rst_n) begin
			err_cnt = 0;
			chk_cnt = 0;
		end else if (check_en) begin
			compare_field("stall", {1'b0, exp_stall}, {1'b0, stall});
			compare_field("d_rs", exp_fwd.d_rs, fwd.d_rs);
			compare_field("d_rt", exp_fwd.d_rt, fwd.d_rt);
			compare_field("e_rs", exp_fwd.e_rs, fwd.e_rs);
			compare_field("e_rt", exp_fwd.e_rt, fwd.e_rt);
			compare_field("m_rt", exp_fwd.m_rt, fwd.m_rt);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/hazard_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_core import hazard_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] instr,
	output logic        stall,
	output fwd_bundle_t fwd
);

	stage_rec_t d_rec;
	stage_rec_t e_rec;
	stage_rec_t m_rec;
	stage_rec_t w_rec;
	use_t_t     d_use;
	logic       md_stall;

	////////////////////////////////////////////////////////////////////////////
	// Decode of the D-stage word

	instr_decode u_decode (
		.instr (instr),
		.d_rec (d_rec),
		.d_use (d_use)
	);

	////////////////////////////////////////////////////////////////////////////
	// In-flight records and multiply/divide occupancy

	stage_track u_track (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (stall),
		.d_rec (d_rec),
		.e_rec (e_rec),
		.m_rec (m_rec),
		.w_rec (w_rec)
	);

	md_busy u_md_busy (
		.clk      (clk),
		.rst_n    (rst_n),
		.e_rec    (e_rec),
		.md_stall (md_stall)
	);

	// Stall and forwarding decisions
	hazard_ctrl u_ctrl (
		.d_rec    (d_rec),
		.d_use    (d_use),
		.e_rec    (e_rec),
		.m_rec    (m_rec),
		.w_rec    (w_rec),
		.md_stall (md_stall),
		.stall    (stall),
		.fwd      (fwd)
	);

endmodule

`default_nettype wire

// ==== rtl/hazard_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl import hazard_pkg::*; (
	input  stage_rec_t  d_rec,
	input  use_t_t      d_use,
	input  stage_rec_t  e_rec,
	input  stage_rec_t  m_rec,
	input  stage_rec_t  w_rec,
	input  logic        md_stall,
	output logic        stall,
	output fwd_bundle_t fwd
);

	logic stall_rs;
	logic stall_rt;

	// Register 0 is never a real dependency
	function automatic logic writes_reg(input logic [4:0] src, input stage_rec_t rec);
		return (src != 5'd0) && rec.grf_we && (rec.wreg == src);
	endfunction

	function automatic logic too_late(input logic [4:0] src, input logic [1:0] t_use,
	                                  input stage_rec_t rec);
		return writes_reg(src, rec) && (rec.t_new > t_use);
	endfunction

	function automatic fwd_sel_e d_select(input logic [4:0] src, input stage_rec_t e,
	                                      input stage_rec_t m, input stage_rec_t w);
		// Load data does not exist in E yet
		if (writes_reg(src, e) && !e.is_lw) return EDATA;
		if (writes_reg(src, m)) return MDATA;
		if (writes_reg(src, w)) return WDATA;
		return ODATA;
	endfunction

	function automatic fwd_sel_e e_select(input logic [4:0] src, input stage_rec_t m,
	                                      input stage_rec_t w);
		if (writes_reg(src, m)) return MDATA;
		if (writes_reg(src, w)) return WDATA;
		return ODATA;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stall

	assign stall_rs = too_late(d_rec.rs, d_use.t_use_rs, e_rec) ||
	                  too_late(d_rec.rs, d_use.t_use_rs, m_rec);
	assign stall_rt = too_late(d_rec.rt, d_use.t_use_rt, e_rec) ||
	                  too_late(d_rec.rt, d_use.t_use_rt, m_rec);

	assign stall = stall_rs || stall_rt || (md_stall && d_rec.is_md);

	////////////////////////////////////////////////////////////////////////////
	// Forwarding selects

	assign fwd.d_rs = d_select(d_rec.rs, e_rec, m_rec, w_rec);
	assign fwd.d_rt = d_select(d_rec.rt, e_rec, m_rec, w_rec);
	assign fwd.e_rs = e_select(e_rec.rs, m_rec, w_rec);
	assign fwd.e_rt = e_select(e_rec.rt, m_rec, w_rec);

	// Store data from W only for a load result
	assign fwd.m_rt = (writes_reg(m_rec.rt, w_rec) && w_rec.is_lw) ? WDATA : ODATA;

	always_comb begin
		if (e_rec.is_lw) begin
			a_no_e_from_load: assert (fwd.d_rs != EDATA && fwd.d_rt != EDATA)
				else $error("hazard_ctrl: D forward from a load in E");
		end
	end

endmodule

`default_nettype wire

// ==== rtl/md_busy.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hazard_macros.svh"

module md_busy import hazard_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  stage_rec_t e_rec,
	output logic       md_stall
);

	localparam int CW = $clog2(`DIV_CYCLES + 1);

	logic [CW-1:0] busy_cnt;

	// Loaded as the starting record leaves E, then counts down
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_cnt <= '0;
		end else begin
			case (e_rec.md_start)
				MD_MULT: busy_cnt <= CW'(`MULT_CYCLES);
				MD_DIV:  busy_cnt <= CW'(`DIV_CYCLES);
				default: begin
					if (busy_cnt != '0) begin
						busy_cnt <= busy_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	// Busy also covers the cycle the start sits in E
	assign md_stall = (busy_cnt != '0) || (e_rec.md_start != MD_NONE);

	a_cnt_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		busy_cnt <= CW'(`DIV_CYCLES)
	) else $error("md_busy: counter %0d above divide latency", busy_cnt);

endmodule

`default_nettype wire

// ==== rtl/stage_track.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_track import hazard_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       stall,
	input  stage_rec_t d_rec,
	output stage_rec_t e_rec,
	output stage_rec_t m_rec,
	output stage_rec_t w_rec
);

	// One stage older means one cycle closer to the result
	function automatic stage_rec_t age(input stage_rec_t rec);
		stage_rec_t aged;
		aged = rec;
		if (rec.t_new != 2'd0) begin
			aged.t_new = rec.t_new - 2'd1;
		end
		return aged;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// E, M and W records

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			e_rec <= '0;
			m_rec <= '0;
			w_rec <= '0;
		end else begin
			// D holds on a stall, E gets a bubble
			if (stall) begin
				e_rec <= '0;
			end else begin
				e_rec <= d_rec;
			end
			m_rec <= age(e_rec);
			w_rec <= age(m_rec);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	// A stalled instruction must not reach E as a writer
	a_bubble_after_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall |=> !e_rec.grf_we
	) else $error("stage_track: E record writes in the cycle after a stall");

endmodule

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hazard_macros.svh"

module instr_decode import hazard_pkg::*; (
	input  logic [31:0] instr,
	output stage_rec_t  d_rec,
	output use_t_t      d_use
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign funct  = instr[5:0];

	// Sources are recorded only when the instruction reads them,
	// so an unused field never matches a writer
	always_comb begin
		d_rec = '0;
		d_use.t_use_rs = 2'd3;
		d_use.t_use_rt = 2'd3;
		case (opcode)
			`OP_SPECIAL: begin
				case (funct)
					`FN_ADDU, `FN_SUBU: begin
						d_rec.rs       = rs;
						d_rec.rt       = rt;
						d_rec.wreg     = rd;
						d_rec.grf_we   = 1'b1;
						d_rec.t_new    = 2'd1;
						d_use.t_use_rs = 2'd1;
						d_use.t_use_rt = 2'd1;
					end
					`FN_JR: begin
						d_rec.rs       = rs;
						d_use.t_use_rs = 2'd0;
					end
					`FN_MULT, `FN_DIV: begin
						d_rec.rs       = rs;
						d_rec.rt       = rt;
						d_rec.is_md    = 1'b1;
						d_rec.md_start = (funct == `FN_MULT) ? MD_MULT : MD_DIV;
						d_use.t_use_rs = 2'd1;
						d_use.t_use_rt = 2'd1;
					end
					`FN_MFHI, `FN_MFLO: begin
						// Reads HI/LO, so it waits on a busy unit
						d_rec.is_md  = 1'b1;
						d_rec.wreg   = rd;
						d_rec.grf_we = 1'b1;
						d_rec.t_new  = 2'd1;
					end
					default: ;
				endcase
			end
			`OP_ORI: begin
				d_rec.rs       = rs;
				d_rec.wreg     = rt;
				d_rec.grf_we   = 1'b1;
				d_rec.t_new    = 2'd1;
				d_use.t_use_rs = 2'd1;
			end
			`OP_LUI: begin
				d_rec.wreg   = rt;
				d_rec.grf_we = 1'b1;
				d_rec.t_new  = 2'd1;
			end
			`OP_LW: begin
				d_rec.rs       = rs;
				d_rec.wreg     = rt;
				d_rec.grf_we   = 1'b1;
				d_rec.is_lw    = 1'b1;
				d_rec.t_new    = `T_MAX;
				d_use.t_use_rs = 2'd1;
			end
			`OP_SW: begin
				// Address at E, store data not until M
				d_rec.rs       = rs;
				d_rec.rt       = rt;
				d_rec.is_sw    = 1'b1;
				d_use.t_use_rs = 2'd1;
				d_use.t_use_rt = 2'd2;
			end
			`OP_BEQ: begin
				d_rec.rs       = rs;
				d_rec.rt       = rt;
				d_use.t_use_rs = 2'd0;
				d_use.t_use_rt = 2'd0;
			end
			`OP_JAL: begin
				// Link address is known in D
				d_rec.wreg   = `REG_RA;
				d_rec.grf_we = 1'b1;
				d_rec.t_new  = 2'd0;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== common/hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

	// Operand source chosen by the forwarding muxes
	typedef enum logic [1:0] {
		ODATA = 2'b00,
		EDATA = 2'b01,
		MDATA = 2'b10,
		WDATA = 2'b11
	} fwd_sel_e;

	// Which operation the multiply/divide unit starts
	typedef enum logic [1:0] {
		MD_NONE = 2'd0,
		MD_MULT = 2'd1,
		MD_DIV  = 2'd2
	} md_start_e;

	////////////////////////////////////////////////////////////////////////////
	// Per-instruction control record, one per pipeline stage

	typedef struct packed {
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] wreg;
		logic [1:0] t_new;     // cycles until the result exists
		logic       grf_we;
		logic       is_lw;
		logic       is_sw;
		logic       is_md;
		md_start_e  md_start;
	} stage_rec_t;

	// Cycles until each D source is really needed
	typedef struct packed {
		logic [1:0] t_use_rs;
		logic [1:0] t_use_rt;
	} use_t_t;

	typedef struct packed {
		fwd_sel_e d_rs;
		fwd_sel_e d_rt;
		fwd_sel_e e_rs;
		fwd_sel_e e_rt;
		fwd_sel_e m_rt;
	} fwd_bundle_t;

endpackage

`default_nettype wire

// ==== common/hazard_macros.svh ====
`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Opcodes

`define OP_SPECIAL 6'b000000
`define OP_ORI     6'b001101
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011
`define OP_BEQ     6'b000100
`define OP_JAL     6'b000011

////////////////////////////////////////////////////////////////////////////
// Function codes under OP_SPECIAL

`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_JR   6'b001000
`define FN_MULT 6'b011000
`define FN_DIV  6'b011010
`define FN_MFHI 6'b010000
`define FN_MFLO 6'b010010

// Multiply/divide unit latency in cycles
`define MULT_CYCLES 5
`define DIV_CYCLES  10

`define REG_RA 5'd31
`define T_MAX  2'd2

`endif
